//--- verilog/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// byte address of the first fetch after reset.
`define FETCH_RESET_ADDR      32'h0000_0100

// instruction address space, in bits.
`define FETCH_ADDR_BITS       16

// log2 of the fetch buffer entries.
`define FETCH_BUF_DEPTH_BITS  2

// 1 lets ebreak halt fetch, 0 ignores it.
`define FETCH_ZICSR           1

`endif

//--- verilog/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

    // halfword address, byte bit 0 always zero.
    typedef logic [`FETCH_ADDR_BITS-1:1] pc_t;

    localparam pc_t PC_RESET = pc_t'(`FETCH_RESET_ADDR >> 1);
    localparam pc_t PC_STEP  = pc_t'(2);   // one 32-bit word.

    // fetch runs until an ebreak parks it.
    typedef enum logic
    {
        FETCH_RUN,
        FETCH_HALT
    } fetch_state_e;

    // source of a pc change, trap wins over branch.
    typedef enum logic [1:0]
    {
        REDIR_NONE,
        REDIR_BRANCH,
        REDIR_TRAP
    } redirect_e;

endpackage

//--- verilog/fetch_addr_gen.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module fetch_addr_gen
(
    input  wire             i_clk,
    input  wire             i_arst_n,
    input  wire             i_buf_has_room,
    input  wire             i_ack,
    input  wire             i_pc_select,
    input  fetch_pkg::pc_t  i_pc_target,
    input  wire             i_trap,
    input  fetch_pkg::pc_t  i_pc_trap,
    input  wire             i_ebreak,
    output fetch_pkg::pc_t  o_pc,
    output logic            o_req,
    output logic            o_flush
);
    import fetch_pkg::*;

    localparam bit HALT_ON_EBREAK = (`FETCH_ZICSR != 0);

    fetch_state_e state;
    redirect_e    cause;
    pc_t          pc;
    logic         fetch_en;
    logic         redirect;
    logic         fetch_done;
    logic         halt_req;

    // trap first, then branch.
    always_comb
    begin
        if (i_trap)
            cause = REDIR_TRAP;
        else if (i_pc_select)
            cause = REDIR_BRANCH;
        else
            cause = REDIR_NONE;
    end

    assign redirect   = (cause != REDIR_NONE);
    assign halt_req   = HALT_ON_EBREAK && i_ebreak;

    // no request while the pc is about to move.
    assign o_req      = fetch_en && (state == FETCH_RUN) && i_buf_has_room && !redirect;
    assign fetch_done = o_req && i_ack;

    assign o_pc    = pc;
    assign o_flush = redirect;

    // holds the bus quiet through reset.
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            fetch_en <= 1'b0;
        else
            fetch_en <= 1'b1;
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            pc <= PC_RESET;
        end
        else
        begin
            case (cause)
                REDIR_TRAP:   pc <= i_pc_trap;
                REDIR_BRANCH: pc <= i_pc_target;
                default:
                begin
                    if (fetch_done)
                        pc <= pc + PC_STEP;   // next word.
                end
            endcase
        end
    end

    // a redirect always restarts fetch, even with ebreak in the same cycle.
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            state <= FETCH_RUN;
        else if (redirect)
            state <= FETCH_RUN;
        else if (halt_req)
            state <= FETCH_HALT;
    end

endmodule

//--- verilog/fetch_buf.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module fetch_buf
#(
    parameter int DEPTH_BITS = `FETCH_BUF_DEPTH_BITS
)
(
    input  wire             i_clk,
    input  wire             i_arst_n,
    input  wire             i_flush,
    input  wire             i_stall,
    input  wire             i_push,
    input  wire [31:0]      i_data,
    input  fetch_pkg::pc_t  i_pc,
    output logic [31:0]     o_data,
    output fetch_pkg::pc_t  o_pc,
    output fetch_pkg::pc_t  o_pc_next,
    output logic            o_not_empty,
    output logic            o_not_full
);
    import fetch_pkg::*;

    localparam int                  DEPTH      = 1 << DEPTH_BITS;
    localparam logic [DEPTH_BITS:0] FULL_LEVEL = (DEPTH_BITS+1)'(DEPTH);

    logic [31:0]           data_mem [DEPTH];
    pc_t                   pc_mem   [DEPTH];
    logic [DEPTH_BITS-1:0] wr_ptr;
    logic [DEPTH_BITS-1:0] rd_ptr;
    logic [DEPTH_BITS:0]   count;
    logic [DEPTH_BITS:0]   level;
    logic                  do_push;
    logic                  do_pop;

    // a flush drops the pending word too.
    assign do_push = i_push && !i_flush;
    assign do_pop  = o_not_empty && !i_stall && !i_flush;

    // entries held plus the one waiting in the push register.
    assign level       = count + {{DEPTH_BITS{1'b0}}, i_push};
    assign o_not_full  = (level < FULL_LEVEL);
    assign o_not_empty = (count != '0);

    assign o_data    = data_mem[rd_ptr];
    assign o_pc      = pc_mem[rd_ptr];
    assign o_pc_next = pc_mem[rd_ptr] + PC_STEP;

    always_ff @(posedge i_clk)
    begin
        if (do_push)
        begin
            data_mem[wr_ptr] <= i_data;
            pc_mem[wr_ptr]   <= i_pc;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else if (i_flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth.
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            count <= '0;
        end
        else if (i_flush)
        begin
            count <= '0;
        end
        else
        begin
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none, or push and pop together.
            endcase
        end
    end

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
(
    input  wire             i_clk,
    input  wire             i_arst_n,
    input  wire             i_stall,
    input  wire             i_pc_select,
    input  fetch_pkg::pc_t  i_pc_target,
    input  wire             i_trap,
    input  fetch_pkg::pc_t  i_pc_trap,
    input  wire             i_ebreak,
    input  wire             i_ack,
    input  wire [31:0]      i_instruction,
    output logic            o_cyc,
    output fetch_pkg::pc_t  o_addr,
    output logic            o_pc_change,
    output logic            o_ready,
    output logic [31:0]     o_instruction,
    output fetch_pkg::pc_t  o_pc,
    output fetch_pkg::pc_t  o_pc_next
);
    import fetch_pkg::*;

    pc_t         fetch_pc;
    logic        fetch_req;
    logic        flush;
    logic        buf_not_full;
    logic        buf_not_empty;
    logic        push_valid;
    logic [31:0] push_data;
    pc_t         push_pc;

    fetch_addr_gen u_addr_gen
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_buf_has_room (buf_not_full),
        .i_ack          (i_ack),
        .i_pc_select    (i_pc_select),
        .i_pc_target    (i_pc_target),
        .i_trap         (i_trap),
        .i_pc_trap      (i_pc_trap),
        .i_ebreak       (i_ebreak),
        .o_pc           (fetch_pc),
        .o_req          (fetch_req),
        .o_flush        (flush)
    );

    // ack is taken one edge before the buffer write.
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            push_valid <= 1'b0;
        else
            push_valid <= fetch_req && i_ack && !flush;   // late ack on flush is lost.
    end

    always_ff @(posedge i_clk)
    begin
        if (fetch_req && i_ack)
        begin
            push_data <= i_instruction;
            push_pc   <= fetch_pc;
        end
    end

    fetch_buf u_buf
    (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (flush),
        .i_stall     (i_stall),
        .i_push      (push_valid),
        .i_data      (push_data),
        .i_pc        (push_pc),
        .o_data      (o_instruction),
        .o_pc        (o_pc),
        .o_pc_next   (o_pc_next),
        .o_not_empty (buf_not_empty),
        .o_not_full  (buf_not_full)
    );

    assign o_cyc       = fetch_req;
    assign o_addr      = fetch_pc;
    assign o_pc_change = flush;
    assign o_ready     = buf_not_empty;

endmodule

//--- verif/fetch_unit_asserts.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module fetch_unit_asserts
(
    input wire             i_clk,
    input wire             i_arst_n,
    input wire             i_stall,
    input wire             i_pc_select,
    input fetch_pkg::pc_t  i_pc_target,
    input wire             i_trap,
    input fetch_pkg::pc_t  i_pc_trap,
    input wire             i_ebreak,
    input wire             i_ack,
    input wire             i_cyc,
    input fetch_pkg::pc_t  i_addr,
    input wire             i_pc_change,
    input wire             i_ready,
    input wire [31:0]      i_instruction,
    input fetch_pkg::pc_t  i_pc,
    input fetch_pkg::pc_t  i_pc_next
);
    import fetch_pkg::*;

    localparam pc_t RESET_PC    = pc_t'(`FETCH_RESET_ADDR / 2);
    localparam int  BUF_ENTRIES = 1 << `FETCH_BUF_DEPTH_BITS;

    int         fail_count = 0;
    pc_t        exp_pc;
    logic [3:0] occ;
    logic       halted;
    logic       first_req;
    logic       redirect;
    logic       consume;
    logic       accept;

    // upper half is the halfword address, lower half its inverse.
    function automatic logic [31:0] expected_word(pc_t a);
        return {16'(a), ~16'(a)};
    endfunction

    assign redirect = i_trap || i_pc_select;
    assign consume  = i_ready && !i_stall && !redirect;
    assign accept   = i_cyc && i_ack;

    // entries held plus the one acked but not yet written.
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            exp_pc    <= RESET_PC;
            occ       <= '0;
            halted    <= 1'b0;
            first_req <= 1'b1;
        end
        else
        begin
            if (redirect)
            begin
                exp_pc <= i_trap ? i_pc_trap : i_pc_target;   // trap wins.
                occ    <= '0;
                halted <= 1'b0;
            end
            else
            begin
                if (consume)
                    exp_pc <= exp_pc + pc_t'(2);
                occ <= occ + 4'(accept) - 4'(consume);
                if (i_ebreak && (`FETCH_ZICSR != 0))
                    halted <= 1'b1;
            end
            if (i_cyc || redirect)
                first_req <= 1'b0;
        end
    end

    a_reset_quiet: assert property (@(posedge i_clk)
        !i_arst_n |-> !i_cyc && !i_ready && !i_pc_change)
    else
    begin
        fail_count++;
        $error("bus, ready or pc change active during reset");
    end

    a_pc_change: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_pc_change == redirect)
    else
    begin
        fail_count++;
        $error("mismatch pc_change: expected %b, actual %b",
               $sampled(redirect), $sampled(i_pc_change));
    end

    a_first_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        first_req && i_cyc |-> i_addr == RESET_PC)
    else
    begin
        fail_count++;
        $error("mismatch first_req: expected %h, actual %h", RESET_PC, $sampled(i_addr));
    end

    a_pc_order: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        consume |-> i_pc == exp_pc)
    else
    begin
        fail_count++;
        $error("mismatch pc_order: expected %h, actual %h", $sampled(exp_pc), $sampled(i_pc));
    end

    a_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        consume |-> i_instruction == expected_word(exp_pc))
    else
    begin
        fail_count++;
        $error("mismatch data: expected %h, actual %h",
               expected_word($sampled(exp_pc)), $sampled(i_instruction));
    end

    a_pc_next: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ready |-> i_pc_next == i_pc + pc_t'(2))
    else
    begin
        fail_count++;
        $error("mismatch pc_next: expected %h, actual %h",
               $sampled(i_pc) + pc_t'(2), $sampled(i_pc_next));
    end

    a_stall_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ready && i_stall && !i_pc_change |=>
            i_ready && $stable(i_instruction) && $stable(i_pc))
    else
    begin
        fail_count++;
        $error("head entry changed while decode was stalled");
    end

    a_no_overrun: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        occ >= 4'(BUF_ENTRIES) |-> !i_cyc)
    else
    begin
        fail_count++;
        $error("bus request raised with the buffer full");
    end

    a_addr_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_cyc && !i_ack |=> $stable(i_addr))
    else
    begin
        fail_count++;
        $error("bus address moved before the acknowledge");
    end

    a_halt_quiet: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        halted |-> !i_cyc)
    else
    begin
        fail_count++;
        $error("bus request raised while fetch is halted");
    end

endmodule

//--- verif/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;
    import fetch_pkg::*;

    logic        i_clk;
    logic        i_arst_n;
    logic        i_stall;
    logic        i_pc_select;
    pc_t         i_pc_target;
    logic        i_trap;
    pc_t         i_pc_trap;
    logic        i_ebreak;
    logic        i_ack;
    logic [31:0] i_instruction;
    logic        o_cyc;
    pc_t         o_addr;
    logic        o_pc_change;
    logic        o_ready;
    logic [31:0] o_instruction;
    pc_t         o_pc;
    pc_t         o_pc_next;

    logic [31:0] lfsr;
    int          ack_wait;
    int          consumed;
    logic        stall_on;
    string       test_name;

    fetch_unit i_dut
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_pc_select   (i_pc_select),
        .i_pc_target   (i_pc_target),
        .i_trap        (i_trap),
        .i_pc_trap     (i_pc_trap),
        .i_ebreak      (i_ebreak),
        .i_ack         (i_ack),
        .i_instruction (i_instruction),
        .o_cyc         (o_cyc),
        .o_addr        (o_addr),
        .o_pc_change   (o_pc_change),
        .o_ready       (o_ready),
        .o_instruction (o_instruction),
        .o_pc          (o_pc),
        .o_pc_next     (o_pc_next)
    );

    bind fetch_unit fetch_unit_asserts u_asserts
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_pc_select   (i_pc_select),
        .i_pc_target   (i_pc_target),
        .i_trap        (i_trap),
        .i_pc_trap     (i_pc_trap),
        .i_ebreak      (i_ebreak),
        .i_ack         (i_ack),
        .i_cyc         (o_cyc),
        .i_addr        (o_addr),
        .i_pc_change   (o_pc_change),
        .i_ready       (o_ready),
        .i_instruction (o_instruction),
        .i_pc          (o_pc),
        .i_pc_next     (o_pc_next)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // memory contents by halfword address.
    function automatic logic [31:0] mem_word(pc_t a);
        return {16'(a), ~16'(a)};
    endfunction

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned rand_bits(int n);
        int unsigned v;
        int          k;
        v = 0;
        for (k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic pc_t rand_pc();
        return pc_t'(rand_bits(15)) & ~pc_t'(1);   // word aligned.
    endfunction

    task automatic stop_on_assert();
        $display("a checker assertion failed during test %s", test_name);
        $display("** FAIL **");
        $fatal(1, "stopping after the first failed check");
    endtask

    task automatic fail_timeout(string what);
        $display("timeout in test %s while waiting for %s", test_name, what);
        $display("** FAIL **");
        $fatal(1, "stopping after a timeout");
    endtask

    // memory model, decode stall and pulse clearing for one clock.
    task automatic tick();
        @(posedge i_clk);
        if (i_dut.u_asserts.fail_count != 0)
            stop_on_assert();
        if (o_ready && !i_stall && !o_pc_change)
            consumed++;
        if (i_ack)
        begin
            i_ack <= 1'b0;
            ack_wait = rand_bits(2);   // 0 to 3 cycles.
        end
        else if (o_cyc)
        begin
            if (ack_wait == 0)
            begin
                i_ack         <= 1'b1;
                i_instruction <= mem_word(o_addr);
            end
            else
            begin
                ack_wait--;
            end
        end
        i_stall     <= stall_on && (rand_bits(2) != 0);
        i_pc_select <= 1'b0;
        i_trap      <= 1'b0;
        i_ebreak    <= 1'b0;
    endtask

    task automatic wait_consumed(int n);
        int target;
        int t;
        target = consumed + n;
        t = 0;
        while (consumed < target)
        begin
            if (t == 100 + 16 * n)
                fail_timeout("instructions to reach decode");
            tick();
            t++;
        end
    endtask

    task automatic wait_ready(logic level);
        int t;
        t = 0;
        while (o_ready !== level)
        begin
            if (t == 200)
                fail_timeout("o_ready to change");
            tick();
            t++;
        end
    endtask

    task automatic wait_cyc_low();
        int t;
        t = 0;
        while (o_cyc !== 1'b0)
        begin
            if (t == 200)
                fail_timeout("o_cyc to drop");
            tick();
            t++;
        end
    endtask

    task automatic send_redirect(logic branch, logic trap);
        i_pc_select <= branch;
        i_pc_target <= rand_pc();
        i_trap      <= trap;
        i_pc_trap   <= rand_pc();
        tick();
    endtask

    task automatic halt_and_resume();
        i_ebreak <= 1'b1;
        tick();
        wait_cyc_low();
        send_redirect(1'b1, 1'b0);
    endtask

    initial
    begin
        int unsigned kind;
        int          r;
        i_arst_n      = 1'b0;
        i_stall       = 1'b0;
        i_pc_select   = 1'b0;
        i_pc_target   = '0;
        i_trap        = 1'b0;
        i_pc_trap     = '0;
        i_ebreak      = 1'b0;
        i_ack         = 1'b0;
        i_instruction = '0;
        lfsr          = 32'h4611;
        ack_wait      = 0;
        consumed      = 0;
        stall_on      = 1'b0;

        test_name = "reset";
        repeat (2) tick();
        i_arst_n <= 1'b1;

        test_name = "sequential";
        wait_consumed(12);

        test_name = "stall";
        stall_on = 1'b1;
        wait_consumed(40);
        stall_on = 1'b0;

        test_name = "branch";
        wait_ready(1'b1);
        send_redirect(1'b1, 1'b0);
        wait_consumed(4);

        test_name = "trap_priority";
        wait_ready(1'b1);
        send_redirect(1'b1, 1'b1);
        wait_consumed(4);

        test_name = "ebreak";
        wait_ready(1'b1);
        i_ebreak <= 1'b1;
        tick();
        wait_cyc_low();
        wait_ready(1'b0);   // old words drain first.
        repeat (8) tick();
        send_redirect(1'b1, 1'b0);
        wait_consumed(4);

        test_name = "random_redirects";
        stall_on = 1'b1;
        for (r = 0; r < 12; r++)
        begin
            wait_consumed(rand_bits(2) + 1);
            kind = rand_bits(2);
            case (kind)
                0:       send_redirect(1'b1, 1'b0);
                1:       send_redirect(1'b0, 1'b1);
                2:       send_redirect(1'b1, 1'b1);
                default: halt_and_resume();
            endcase
        end
        stall_on = 1'b0;
        wait_consumed(4);

        tick();
        tick();
        @(negedge i_clk);
        if (i_dut.u_asserts.fail_count == 0)
        begin
            $display("** PASS **");
            $finish;
        end
        else
        begin
            $display("** FAIL **");
            $fatal(1, "checker reported failures");
        end
    end

endmodule

//--- fetch_unit.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_addr_gen.sv
verilog/fetch_buf.sv
verilog/fetch_unit.sv
verif/fetch_unit_asserts.sv
verif/fetch_unit_tb.sv
